//--- design/hanCarlson_defs.svh
// Han-Carlson adder constants
// Operand width, number of prefix levels on odd bit positions and the
// pipeline latency from operand sampling to a visible result

`ifndef HAN_CARLSON_DEFS_SVH
`define HAN_CARLSON_DEFS_SVH

// Operand width in bits
`define HC_WIDTH 32

// Kogge-Stone levels on odd positions, log2 of the width
`define HC_ODD_LEVELS 5

// Rising edges from operand sampling to the result on s
`define HC_LATENCY 2

`endif

//--- design/hanCarlsonPkg.sv
// Han-Carlson adder types
// Operand and result words, and the group generate/propagate bundle
// passed from the odd-position prefix tree to the sum stage

`include "hanCarlson_defs.svh"

package hanCarlsonPkg;

  // One adder operand
  typedef logic [`HC_WIDTH-1:0] operandT;

  // Result word, carry-out is the top bit
  typedef logic [`HC_WIDTH:0] sumT;

  // Group generate and propagate per bit position
  typedef struct packed {
    operandT g; // Group generate
    operandT p; // Group propagate
  } gpVecT;

endpackage

//--- design/hcOddPrefixTree.sv
// Han-Carlson prefix tree, odd bit positions
// Forms the bitwise generate and propagate of the two operands, then
// runs the Kogge-Stone levels with doubling span on odd positions only.
// After the last level each odd position holds the group signal from
// bit 0 up to itself, while even positions still carry bitwise values.

`timescale 1ns/1ps

`include "hanCarlson_defs.svh"

module hcOddPrefixTree
(
  input  hanCarlsonPkg::operandT a,
  input  hanCarlsonPkg::operandT b,
  output hanCarlsonPkg::operandT bitProp,
  output hanCarlsonPkg::gpVecT   oddGp
);

  // Level 0 is bitwise, level HC_ODD_LEVELS is the tree output
  wire hanCarlsonPkg::gpVecT levelGp [0:`HC_ODD_LEVELS];

  logic [2:0] lowPairSum; // Carry check on bits 1:0

  assign levelGp[0].g = a & b;
  assign levelGp[0].p = a ^ b;

  for (genvar lvl = 1; lvl <= `HC_ODD_LEVELS; lvl++)
  begin : gLevel
    localparam int Span = 1 << (lvl - 1);

    for (genvar i = 0; i < `HC_WIDTH; i++)
    begin : gBit
      if (((i % 2) == 1) && (i >= Span))
      begin : gMerge
        // Carry operator, upper group i with lower group i-Span
        assign levelGp[lvl].g[i] = levelGp[lvl-1].g[i] |
                                   (levelGp[lvl-1].p[i] & levelGp[lvl-1].g[i-Span]);
        assign levelGp[lvl].p[i] = levelGp[lvl-1].p[i] & levelGp[lvl-1].p[i-Span];
      end
      else
      begin : gPass
        assign levelGp[lvl].g[i] = levelGp[lvl-1].g[i]; // Even or already complete
        assign levelGp[lvl].p[i] = levelGp[lvl-1].p[i];
      end
    end
  end

  assign bitProp = levelGp[0].p;
  assign oddGp   = levelGp[`HC_ODD_LEVELS];

  assign lowPairSum = {1'b0, a[1:0]} + {1'b0, b[1:0]};

  // Bit 1 is closed after the first level and must survive all later ones
  bitOneCarry: assert final ($isunknown({a[1:0], b[1:0]}) || (oddGp.g[1] == lowPairSum[2]))
    else $error("hcOddPrefixTree: group generate at bit 1 differs from the two-bit carry");

endmodule

//--- design/hcSumStage.sv
// Han-Carlson final level and sum
// Fills in each even position above zero from its odd neighbour below,
// so every position holds the carry out of bits 0 up to itself. The sum
// bits are these carries XORed with the next bitwise propagate, and the
// top carry becomes the carry-out. Carry-in is zero.

`timescale 1ns/1ps

`include "hanCarlson_defs.svh"

module hcSumStage
(
  input  hanCarlsonPkg::gpVecT   oddGp,
  input  hanCarlsonPkg::operandT bitProp,
  output hanCarlsonPkg::sumT     sum
);

  hanCarlsonPkg::operandT carry; // Carry out of bits i:0

  // Even fill-in level
  always_comb
  begin
    carry = oddGp.g; // Odd positions and bit 0 are already complete
    for (int i = 2; i < `HC_WIDTH; i += 2)
    begin
      carry[i] = oddGp.g[i] | (oddGp.p[i] & oddGp.g[i - 1]);
    end
  end

  // Sum formation
  always_comb
  begin
    sum[0] = bitProp[0]; // No carry into bit 0
    for (int i = 1; i < `HC_WIDTH; i++)
    begin
      sum[i] = carry[i - 1] ^ bitProp[i];
    end
    sum[`HC_WIDTH] = carry[`HC_WIDTH - 1]; // Carry-out
  end

endmodule

//--- design/hanCarlsonAdd32.sv
// Pipelined 32-bit Han-Carlson adder
// Operands are registered on every clock, summed by the parallel-prefix
// network and the 33-bit result is registered into s. Latency is two
// edges and a new operand pair is accepted every cycle.

`timescale 1ns/1ps

`include "hanCarlson_defs.svh"

module hanCarlsonAdd32
(
  input  logic                   clk,
  input  logic                   rst,
  input  hanCarlsonPkg::operandT x,
  input  hanCarlsonPkg::operandT y,
  output hanCarlsonPkg::sumT     s
);

  hanCarlsonPkg::operandT xReg;
  hanCarlsonPkg::operandT yReg;
  hanCarlsonPkg::operandT bitProp; // Bitwise propagate
  hanCarlsonPkg::gpVecT   oddGp;   // Tree output
  hanCarlsonPkg::sumT     sumComb; // Unregistered sum

  // Tree depth must cover the full width
  if ((1 << `HC_ODD_LEVELS) != `HC_WIDTH)
  begin : gDepthCheck
    $error("hanCarlsonAdd32: HC_ODD_LEVELS does not match HC_WIDTH");
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      xReg <= '0;
      yReg <= '0;
      s    <= '0;
    end
    else
    begin
      xReg <= x;
      yReg <= y;
      s    <= sumComb;
    end
  end

  hcOddPrefixTree uTree
  (
    .a       (xReg),
    .b       (yReg),
    .bitProp (bitProp),
    .oddGp   (oddGp)
  );

  hcSumStage uSum
  (
    .oddGp   (oddGp),
    .bitProp (bitProp),
    .sum     (sumComb)
  );

  property pResetClears;
    @(posedge clk) rst |=> (s == '0);
  endproperty

  aResetClears: assert property (pResetClears)
    else $error("hanCarlsonAdd32: s not cleared after a reset edge");

  aNoUnknown: assert property (@(posedge clk) disable iff (rst) !$isunknown(s))
    else $error("hanCarlsonAdd32: s is unknown after reset");

  // Carry-out follows the operands sampled HC_LATENCY edges back
  property pCarryOut;
    @(posedge clk) disable iff (rst)
      (!$past(rst, 1) && !$past(rst, `HC_LATENCY)) |->
        (s[`HC_WIDTH] == (({1'b0, $past(x, `HC_LATENCY)} + {1'b0, $past(y, `HC_LATENCY)})
                          >> `HC_WIDTH));
  endproperty

  aCarryOut: assert property (pCarryOut)
    else $error("hanCarlsonAdd32: carry-out does not match operand overflow");

endmodule

//--- verification/hcChecker.sv
// Han-Carlson adder result checker
// Takes the name and expected sum of each test as it is driven, delays
// them by the adder latency and compares with s once it has settled.
// Prints one line per test and keeps the running counts.

`timescale 1ns/1ps

`include "hanCarlson_defs.svh"

module hcChecker
(
  input  logic                   clk,
  input  hanCarlsonPkg::sumT     s,
  input  logic                   inValid,
  input  logic [127:0]           inName,
  input  hanCarlsonPkg::sumT     inExpect,
  output int                     numChecked,
  output int                     numFailed
);

  // Delay line, index 0 is the newest entry
  logic               pipeValid  [0:`HC_LATENCY-1];
  logic [127:0]       pipeName   [0:`HC_LATENCY-1];
  hanCarlsonPkg::sumT pipeExpect [0:`HC_LATENCY-1];

  initial
  begin
    numChecked = 0;
    numFailed  = 0;
    for (int i = 0; i < `HC_LATENCY; i++)
    begin
      pipeValid[i]  = 1'b0;
      pipeName[i]   = '0;
      pipeExpect[i] = '0;
    end
  end

  always @(posedge clk)
  begin
    for (int i = `HC_LATENCY - 1; i > 0; i--)
    begin
      pipeValid[i]  <= pipeValid[i-1];
      pipeName[i]   <= pipeName[i-1];
      pipeExpect[i] <= pipeExpect[i-1];
    end
    pipeValid[0]  <= inValid;
    pipeName[0]   <= inName;
    pipeExpect[0] <= inExpect;
  end

  // s changed on the rising edge, compare half a cycle later
  always @(negedge clk)
  begin
    if (pipeValid[`HC_LATENCY-1])
    begin
      if (s === pipeExpect[`HC_LATENCY-1])
      begin
        $display("PASS %0s", pipeName[`HC_LATENCY-1]);
      end
      else
      begin
        $display("FAILED %0s expected %h actual %h", pipeName[`HC_LATENCY-1],
                 pipeExpect[`HC_LATENCY-1], s);
        numFailed = numFailed + 1;
      end
      numChecked = numChecked + 1;
    end
  end

endmodule

//--- verification/tbHanCarlson.sv
// Testbench for the pipelined Han-Carlson adder
// Reads the test trace, drives one operand pair per cycle on the
// falling edge and lets the checker compare results after the
// pipeline latency. A watchdog bounds the run time.

`timescale 1ns/1ps

`include "hanCarlson_defs.svh"

module tbHanCarlson;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 2;

  logic                   clk;
  logic                   rst;
  hanCarlsonPkg::operandT x;
  hanCarlsonPkg::operandT y;
  hanCarlsonPkg::sumT     s;

  logic                   inValid;
  logic [127:0]           inName;
  hanCarlsonPkg::sumT     inExpect;
  int                     numChecked;
  int                     numFailed;

  // Trace contents
  logic [127:0]           nameQ   [$];
  logic                   rstQ    [$];
  hanCarlsonPkg::operandT aQ      [$];
  hanCarlsonPkg::operandT bQ      [$];
  hanCarlsonPkg::sumT     expectQ [$];

  integer seed = 32'hb240_cbca;
  bit     loadOk;
  bit     loaded;

  hanCarlsonAdd32 u_dut
  (
    .clk (clk),
    .rst (rst),
    .x   (x),
    .y   (y),
    .s   (s)
  );

  hcChecker uChecker
  (
    .clk        (clk),
    .s          (s),
    .inValid    (inValid),
    .inName     (inName),
    .inExpect   (inExpect),
    .numChecked (numChecked),
    .numFailed  (numFailed)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Fills the trace queues, skips comments and blank lines
  task automatic readTrace(output bit ok);
    integer       fd;
    integer       fields;
    string        line;
    logic [127:0] nm;
    logic [31:0]  r;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [35:0]  e;
    ok = 1'b0;
    fd = $fopen("verification/hc_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file verification/hc_trace.txt");
      return;
    end
    ok = 1'b1;
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#")
      begin
        fields = $sscanf(line, "%s %h %h %h %h", nm, r, a, b, e);
        if (fields != 5)
        begin
          $display("Trace line is malformed: %s", line);
          ok = 1'b0;
        end
        else
        begin
          nameQ.push_back(nm);
          rstQ.push_back(r[0]);
          aQ.push_back(a);
          bQ.push_back(b);
          expectQ.push_back(e[`HC_WIDTH:0]);
        end
      end
    end
    $fclose(fd);
    if (nameQ.size() == 0)
    begin
      $display("Trace file holds no tests");
      ok = 1'b0;
    end
  endtask

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    x        = '0;
    y        = '0;
    inValid  = 1'b0;
    inName   = '0;
    inExpect = '0;
    loaded   = 1'b0;
    readTrace(loadOk);
    loaded = 1'b1;
    if (!loadOk)
    begin
      $display("Result: FAILED");
      $finish;
    end
    else
    begin
      // Junk on the operands must not reach s while in reset
      for (int i = 0; i < ResetCycles; i++)
      begin
        if (i > 0)
        begin
          @(negedge clk);
        end
        x        = $random(seed);
        y        = $random(seed);
        inValid  = 1'b1;
        inName   = "reset";
        inExpect = '0;
      end
      foreach (nameQ[i])
      begin
        @(negedge clk);
        rst      = rstQ[i];
        x        = aQ[i];
        y        = bQ[i];
        inName   = nameQ[i];
        inExpect = expectQ[i];
      end
      @(negedge clk);
      rst     = 1'b0;
      inValid = 1'b0;
      wait (numChecked == nameQ.size() + ResetCycles);
      $display("Tests: %0d run, %0d failed", numChecked, numFailed);
      if (numFailed == 0)
      begin
        $display("Result: PASSED");
      end
      else
      begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

  // Watchdog
  initial
  begin
    wait (loaded);
    #((nameQ.size() + ResetCycles + `HC_LATENCY + 10) * ClkPeriod);
    $display("Timeout, only %0d results were checked", numChecked);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verification/hc_trace.txt
# Han-Carlson adder test trace, one test per line
# Columns: name, rst for that cycle, operand a, operand b, expected 33-bit sum (hex)
# Corner sums
zero_zero       0 00000000 00000000 000000000
ones_plus_one   0 FFFFFFFF 00000001 100000000
ones_ones       0 FFFFFFFF FFFFFFFF 1FFFFFFFE
alt_a5          0 AAAAAAAA 55555555 0FFFFFFFF
alt_aa          0 AAAAAAAA AAAAAAAA 155555554
alt_55          0 55555555 55555555 0AAAAAAAA
max_zero        0 FFFFFFFF 00000000 0FFFFFFFF
msb_msb         0 80000000 80000000 100000000
one_one         0 00000001 00000001 000000002
# Carry chains, one plus k low ones
chain01         0 00000001 00000001 000000002
chain02         0 00000001 00000003 000000004
chain03         0 00000001 00000007 000000008
chain04         0 00000001 0000000F 000000010
chain05         0 00000001 0000001F 000000020
chain06         0 00000001 0000003F 000000040
chain07         0 00000001 0000007F 000000080
chain08         0 00000001 000000FF 000000100
chain09         0 00000001 000001FF 000000200
chain10         0 00000001 000003FF 000000400
chain11         0 00000001 000007FF 000000800
chain12         0 00000001 00000FFF 000001000
chain13         0 00000001 00001FFF 000002000
chain14         0 00000001 00003FFF 000004000
chain15         0 00000001 00007FFF 000008000
chain16         0 00000001 0000FFFF 000010000
chain17         0 00000001 0001FFFF 000020000
chain18         0 00000001 0003FFFF 000040000
chain19         0 00000001 0007FFFF 000080000
chain20         0 00000001 000FFFFF 000100000
chain21         0 00000001 001FFFFF 000200000
chain22         0 00000001 003FFFFF 000400000
chain23         0 00000001 007FFFFF 000800000
chain24         0 00000001 00FFFFFF 001000000
chain25         0 00000001 01FFFFFF 002000000
chain26         0 00000001 03FFFFFF 004000000
chain27         0 00000001 07FFFFFF 008000000
chain28         0 00000001 0FFFFFFF 010000000
chain29         0 00000001 1FFFFFFF 020000000
chain30         0 00000001 3FFFFFFF 040000000
chain31         0 00000001 7FFFFFFF 080000000
chain32         0 00000001 FFFFFFFF 100000000
# Pseudo-random operands, back to back
rand01          0 3A7F1C92 5B0E6D4F 0958D89E1
rand02          0 C4E21B07 7D93F2A8 142760DAF
rand03          0 9F00A3E5 60FF5C1B 100000000
rand04          0 1234ABCD 0F0F0F0F 02143BADC
rand05          0 7FFFFFFF 7FFFFFFF 0FFFFFFFE
rand06          0 80000001 7FFFFFFF 100000000
rand07          0 E9A3B6C2 2B7D4E19 1152104DB
rand08          0 0A1B2C3D F5E4D3C2 0FFFFFFFF
rand09          0 6C3E9D21 4A8F7E55 0B6CE1B76
rand10          0 55AA33CC AA55CC34 100000000
rand11          0 3141592F 27182818 058598147
rand12          0 DEADBEEF CAFEBABE 1A9AC79AD
rand13          0 00FF00FF 00010001 001000100
rand14          0 89ABCDEF 76543210 0FFFFFFFF
rand15          0 89ABCDEF 76543211 100000000
rand16          0 1F2E3D4C 5B6A7988 07A98B6D4
rand17          0 F0E1D2C3 0F1E2D3C 0FFFFFFFF
rand18          0 A1B2C3D4 E5F60718 187A8CAEC
rand19          0 13579BDF 2468ACE0 037C048BF
rand20          0 6E5D4C3B 9A8B7C6D 108E8C8A8
# Reset pulse, the result before it and its own result read zero
pre_reset       0 12345678 11111111 000000000
rst_pulse       1 DEADBEEF 00000001 000000000
post_reset      0 12345678 11111111 023456789
rand21          0 00000000 9C2B4E7F 09C2B4E7F
rand22          0 40000000 40000000 080000000
rand23          0 C0000000 40000000 100000000
rand24          0 2D4C6B8A 1E3F5A7C 04B8BC606
rand25          0 FEDCBA98 01234567 0FFFFFFFF
rand26          0 FEDCBA98 01234568 100000000
rand27          0 7A3C9E51 3B6D2F08 0B5A9CD59
rand28          0 0000FFFF 0000FFFF 00001FFFE
rand29          0 8F3A0C6D 8E2B1F94 11D652C01
rand30          0 5C4D3E2F 3A2B1C0D 096785A3C
rand31          0 B7E15163 8AED2A6A 142CE7BCD
rand32          0 243F6A88 85A308D3 0A9E2735B
rand33          0 13198A2E 03707344 01689FD72
rand34          0 A4093822 299F31D0 0CDA869F2
rand35          0 082EFA98 EC4E6C89 0F47D6721
rand36          0 452821E6 38D01377 07DF8355D
rand37          0 BE5466CF 34E90C6C 0F33D733B
rand38          0 C0AC29B7 C97C50DD 18A287A94
rand39          0 3F84D5B5 B5470917 0F4CBDECC
rand40          0 9216D5D9 8979FB1B 11B90D0F4
rand41          0 12345678 EDCBA987 0FFFFFFFF
rand42          0 12345678 EDCBA988 100000000
rand43          0 00000001 00000000 000000001

//--- hanCarlsonAdd.f
+incdir+design
design/hanCarlsonPkg.sv
design/hcOddPrefixTree.sv
design/hcSumStage.sv
design/hanCarlsonAdd32.sv
verification/hcChecker.sv
verification/tbHanCarlson.sv

//--- Bender.yml
package:
  name: hanCarlsonAdd

sources:
  - include_dirs:
      - design
    files:
      - design/hanCarlsonPkg.sv
      - design/hcOddPrefixTree.sv
      - design/hcSumStage.sv
      - design/hanCarlsonAdd32.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/hcChecker.sv
      - verification/tbHanCarlson.sv
